/* sources.f */
+incdir+.
sha256_frontend_pkg.sv
sys_bus_slave.sv
ctrl_regs.sv
msg_fifo.sv
sha256_frontend_top.sv
tb_sha256_frontend.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_sha256_frontend -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
  exit 0
fi
exit 1

/* tb_tasks.svh */
// ----------------------------------------
// bookkeeping
// ----------------------------------------
task automatic check_value(input string name, input logic [BLOCK_W-1:0] got,
                           input logic [BLOCK_W-1:0] exp);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
  end
endtask

task automatic begin_test(input string name);
  test_name          = name;
  test_errs_at_start = err_count;
endtask

task automatic end_test();
  if (err_count == test_errs_at_start) begin
    tests_passed++;
    $display("test %s: ok", test_name);
  end else begin
    tests_failed++;
    $display("test %s: failed with %0d errors", test_name, err_count - test_errs_at_start);
  end
endtask

task automatic idle_cycles(input int n);
  repeat (n) begin
    @(posedge clk_100mhz);
    #1;
  end
endtask

// ----------------------------------------
// bus and engine access
// ----------------------------------------
task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic is_write, output logic [31:0] rdata);
  int waited;
  sys_req.addr  = addr;
  sys_req.wdata = wdata;
  sys_req.wen   = is_write;
  sys_req.ren   = !is_write;
  @(posedge clk_100mhz);
  #1;
  sys_req.wen = 1'b0;  // request lasts one cycle
  sys_req.ren = 1'b0;
  waited      = 1;
  while (!sys_rsp.ack && waited < ACK_TIMEOUT) begin
    @(posedge clk_100mhz);
    #1;
    waited++;
  end
  if (!sys_rsp.ack) begin
    err_count++;
    $display("no ack within %0d cycles for access to address %08h", ACK_TIMEOUT, addr);
  end else begin
    check_value("ack latency in cycles", 512'(waited), 512'(1));
  end
  rdata = sys_rsp.rdata;  // valid while ack is high
  @(posedge clk_100mhz);
  #1;
  check_value("sys_rsp_o.ack", 512'(sys_rsp.ack), 512'(1'b0));  // single-cycle ack
endtask

task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
  logic [31:0] unused_rdata;
  bus_access(addr, wdata, 1'b1, unused_rdata);
endtask

task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
  bus_access(addr, 32'h0, 1'b0, rdata);
endtask

task automatic read_check(input logic [31:0] addr, input string name, input logic [31:0] exp);
  logic [31:0] rdata;
  bus_read(addr, rdata);
  check_value(name, 512'(rdata), 512'(exp));
endtask

// poll SHA_STATUS until one bit reaches a value
task automatic wait_status_bit(input int bit_idx, input logic value, input string what);
  logic [31:0] rdata;
  int          polls;
  polls = 0;
  bus_read(32'(SHA_STATUS), rdata);
  while (rdata[bit_idx] !== value && polls < POLL_TIMEOUT) begin
    bus_read(32'(SHA_STATUS), rdata);
    polls++;
  end
  if (rdata[bit_idx] !== value) begin
    err_count++;
    $display("SHA_STATUS never showed %s within %0d reads", what, POLL_TIMEOUT);
  end
endtask

task automatic pop_block();
  eng_pop = 1'b1;
  @(posedge clk_100mhz);
  #1;
  eng_pop = 1'b0;
endtask

task automatic push_pairs(input int first_pair, input int num_pairs);
  for (int i = 2 * first_pair; i < 2 * (first_pair + num_pairs); i++) begin
    words[i] = $random(seed);
    bus_write(32'(SHA_PUSH), words[i]);  // even index low, odd index high
  end
endtask

// ----------------------------------------
// directed tests
// ----------------------------------------
task automatic test_reset_state();
  begin_test("reset_state");
  read_check(32'(CTRL), "CTRL", 32'h0);
  read_check(32'(SHA_CTRL), "SHA_CTRL", 32'h0);
  read_check(32'(STATUS), "STATUS", 32'h0);
  read_check(32'(VERSION), "VERSION", BUILD_DATE);
  read_check(32'(SHA_STATUS), "SHA_STATUS", 32'h10);  // empty fifo, idle engine
  read_check(32'h0000_0008, "unmapped 0x008", 32'h0);
  bus_write(32'h0000_0200, 32'hdead_beef);
  read_check(32'h0000_0200, "unmapped 0x200", 32'h0);
  read_check(32'(CTRL), "CTRL after unmapped write", 32'h0);
  check_value("activated_o", 512'(activated), 512'(1'b0));
  check_value("eng_req_o.start", 512'(eng_req.start), 512'(1'b0));
  end_test();
endtask

task automatic test_enable();
  begin_test("enable");
  bus_write(32'(CTRL), 32'h0000_5a01);
  read_check(32'(CTRL), "CTRL", 32'h0000_5a01);
  idle_cycles(1);  // status trails the register
  read_check(32'(STATUS), "STATUS enabled", 32'h11);
  check_value("activated_o", 512'(activated), 512'(1'b1));
  bus_write(32'(CTRL), 32'h0);
  idle_cycles(1);
  read_check(32'(STATUS), "STATUS disabled", 32'h0);
  check_value("activated_o", 512'(activated), 512'(1'b0));
  end_test();
endtask

task automatic test_oneshot();
  int pulses_before;
  begin_test("oneshot");
  pulses_before = start_pulses;
  bus_write(32'(SHA_CTRL), 32'h0000_0102);  // start plus a plain bit
  idle_cycles(2);
  check_value("eng_req_o.start pulses", 512'(start_pulses - pulses_before), 512'(1));
  check_value("eng_req_o.start", 512'(eng_req.start), 512'(1'b0));
  read_check(32'(SHA_CTRL), "SHA_CTRL after pulse", 32'h0000_0100);
  end_test();
endtask

task automatic test_push_block();
  logic [BLOCK_W-1:0] exp_block;
  logic [31:0]        rdata;
  begin_test("push_block");
  bus_write(32'(CTRL), 32'h1);
  idle_cycles(2);  // enable reaches the fifo
  push_pairs(0, 8);
  wait_status_bit(7, 1'b1, "block_avail");
  bus_read(32'(SHA_STATUS), rdata);
  check_value("SHA_STATUS.empty", 512'(rdata[4]), 512'(1'b0));
  for (int i = 0; i < 16; i++)
    exp_block[32*i +: 32] = words[i];  // first word lowest
  check_value("eng_req_o.block", eng_req.block, exp_block);
  pop_block();
  wait_status_bit(4, 1'b1, "empty after pop");
  push_pairs(0, 8);
  wait_status_bit(7, 1'b1, "block_avail before sha reset");
  bus_write(32'(SHA_CTRL), 32'h1);
  wait_status_bit(4, 1'b1, "empty after sha reset");
  end_test();
endtask

task automatic test_hash_readback();
  logic [31:0] rdata;
  begin_test("hash_readback");
  eng_ready = 1'b1;
  eng_valid = 1'b0;
  bus_read(32'(SHA_STATUS), rdata);
  check_value("SHA_STATUS ready/valid", 512'(rdata[1:0]), 512'(2'b01));
  eng_valid = 1'b1;
  bus_read(32'(SHA_STATUS), rdata);
  check_value("SHA_STATUS ready/valid", 512'(rdata[1:0]), 512'(2'b11));
  for (int k = 0; k < 8; k++)
    read_check(32'(SHA_HASH0) + 32'(4 * k), $sformatf("SHA_HASH%0d", k),
               MODEL_HASH[32*k +: 32]);
  end_test();
endtask

task automatic test_full();
  logic [BLOCK_W-1:0] exp_block;
  logic [31:0]        rdata;
  begin_test("full");
  push_pairs(0, 127);
  bus_read(32'(SHA_STATUS), rdata);
  check_value("SHA_STATUS.almost_full", 512'(rdata[5]), 512'(1'b1));
  push_pairs(127, 3);  // last two pairs find no room
  bus_read(32'(SHA_STATUS), rdata);
  check_value("SHA_STATUS.full", 512'(rdata[6]), 512'(1'b1));
  check_value("SHA_STATUS.almost_full", 512'(rdata[5]), 512'(1'b0));
  for (int b = 0; b < 16; b++) begin
    wait_status_bit(7, 1'b1, "block_avail before pop");
    for (int i = 0; i < 16; i++)
      exp_block[32*i +: 32] = words[16*b + i];
    check_value($sformatf("eng_req_o.block %0d", b), eng_req.block, exp_block);
    pop_block();
  end
  wait_status_bit(4, 1'b1, "empty after 16 pops");
  bus_read(32'(SHA_STATUS), rdata);
  check_value("SHA_STATUS.block_avail", 512'(rdata[7]), 512'(1'b0));
  pop_block();  // nothing left, ignored
  bus_read(32'(SHA_STATUS), rdata);
  check_value("SHA_STATUS.empty", 512'(rdata[4]), 512'(1'b1));
  end_test();
endtask

/* tb_sha256_frontend.sv */
`timescale 1ns/1ps

module tb_sha256_frontend;
  import sha256_frontend_pkg::*;

  localparam int ACK_TIMEOUT  = 8;    // cycles until an ack must show
  localparam int POLL_TIMEOUT = 64;   // status reads before giving up
  localparam int NUM_WORDS    = 260;  // 130 pairs for the full test

  // known digest returned by the engine model
  localparam logic [HASH_W-1:0] MODEL_HASH =
    256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;

  logic        clk_100mhz = 1'b0;
  logic        rstn_i;
  sys_req_t    sys_req;
  sys_rsp_t    sys_rsp;
  logic        activated;
  eng_req_t    eng_req;
  logic        eng_pop;     // engine consumes a block
  eng_rsp_t    eng_rsp;
  logic        eng_ready;   // engine model state
  logic        eng_valid;
  integer      seed;
  int          err_count;
  int          check_count;
  int          tests_passed;
  int          tests_failed;
  int          test_errs_at_start;
  int          start_pulses;  // start strobes seen so far
  string       test_name;
  logic [31:0] words [0:NUM_WORDS-1];  // pushed message words

  always #5 clk_100mhz = ~clk_100mhz;  // 100 MHz

  sha256_frontend_top uut (
    .clk_100mhz (clk_100mhz),
    .rstn_i     (rstn_i),
    .sys_req_i  (sys_req),
    .sys_rsp_o  (sys_rsp),
    .activated_o(activated),
    .eng_req_o  (eng_req),
    .eng_pop_i  (eng_pop),
    .eng_rsp_i  (eng_rsp)
  );

  // ----------------------------------------
  // engine model
  // ----------------------------------------
  assign eng_rsp = {eng_ready, eng_valid, MODEL_HASH};

  // start is a one-cycle kick, count it mid-cycle
  always @(negedge clk_100mhz) begin
    if (eng_req.start)
      start_pulses++;
  end

  `include "tb_tasks.svh"

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    seed         = 32'h37d6;
    sys_req      = '0;
    eng_pop      = 1'b0;
    eng_ready    = 1'b0;
    eng_valid    = 1'b0;
    err_count    = 0;
    check_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    start_pulses = 0;
    rstn_i       = 1'b0;
    repeat (2) @(posedge clk_100mhz);
    #1;
    rstn_i = 1'b1;  // from here on inputs move 1 ns after the edge

    test_reset_state();
    test_enable();
    test_oneshot();
    test_push_block();
    test_hash_readback();
    test_full();

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, check_count, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // whole run bound, well past the longest test
  initial begin
    #1_000_000;
    $display("simulation ran too long, watchdog stopped it");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* sha256_frontend_top.sv */
`timescale 1ns/1ps

module sha256_frontend_top (
  input  logic                          clk_100mhz,
  input  logic                          rstn_i,
  input  sha256_frontend_pkg::sys_req_t sys_req_i,
  output sha256_frontend_pkg::sys_rsp_t sys_rsp_o,
  output logic                          activated_o,
  output sha256_frontend_pkg::eng_req_t eng_req_o,
  input  logic                          eng_pop_i,  // engine takes the oldest block
  input  sha256_frontend_pkg::eng_rsp_t eng_rsp_i
);
  import sha256_frontend_pkg::*;

  logic               ctrl_we;
  logic               sha_ctrl_we;
  logic [DATA_W-1:0]  wdata;
  logic               push;
  logic [DATA_W-1:0]  ctrl;
  logic [DATA_W-1:0]  sha_ctrl;
  sha_ctrl_t          flags;
  logic               block_rstn;
  logic               sha_rstn;
  fifo_stat_t         fifo_stat;
  logic [BLOCK_W-1:0] fifo_block;

  // ----------------------------------------
  // bus front end
  // ----------------------------------------
  sys_bus_slave u_bus (
    .clk_100mhz   (clk_100mhz),
    .rstn_i       (rstn_i),
    .sys_req_i    (sys_req_i),
    .sys_rsp_o    (sys_rsp_o),
    .ctrl_we_o    (ctrl_we),
    .sha_ctrl_we_o(sha_ctrl_we),
    .wdata_o      (wdata),
    .push_o       (push),
    .ctrl_i       (ctrl),
    .sha_ctrl_i   (sha_ctrl),
    .activated_i  (block_rstn),  // status bit 0
    .sha_en_i     (sha_rstn),    // status bit 4
    .fifo_stat_i  (fifo_stat),
    .eng_rsp_i    (eng_rsp_i)
  );

  ctrl_regs u_ctrl (
    .clk_100mhz   (clk_100mhz),
    .rstn_i       (rstn_i),
    .ctrl_we_i    (ctrl_we),
    .sha_ctrl_we_i(sha_ctrl_we),
    .wdata_i      (wdata),
    .ctrl_o       (ctrl),
    .sha_ctrl_o   (sha_ctrl),
    .flags_o      (flags),
    .block_rstn_o (block_rstn),
    .sha_rstn_o   (sha_rstn)
  );

  // ----------------------------------------
  // message path
  // ----------------------------------------
  msg_fifo u_fifo (
    .clk_100mhz(clk_100mhz),
    .rstn_i    (rstn_i),
    .sha_rstn_i(sha_rstn),
    .restart_i (flags.start | flags.reset),
    .push_i    (push),
    .wdata_i   (wdata),
    .pop_i     (eng_pop_i),
    .block_o   (fifo_block),
    .stat_o    (fifo_stat)
  );

  assign eng_req_o.block = fifo_block;
  assign eng_req_o.start = flags.start;  // one-cycle kick
  assign activated_o     = block_rstn;

endmodule

/* msg_fifo.sv */
`timescale 1ns/1ps

module msg_fifo (
  input  logic                                    clk_100mhz,
  input  logic                                    rstn_i,
  input  logic                                    sha_rstn_i,
  input  logic                                    restart_i,
  input  logic                                    push_i,
  input  logic [sha256_frontend_pkg::DATA_W-1:0]  wdata_i,
  input  logic                                    pop_i,
  output logic [sha256_frontend_pkg::BLOCK_W-1:0] block_o,
  output sha256_frontend_pkg::fifo_stat_t         stat_o
);
  import sha256_frontend_pkg::*;

  logic [DATA_W-1:0]     lo_word_q;  // first half of a pair
  logic                  hi_sel_q;   // next push is the high word
  logic [MSG_W-1:0]      mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;   // entry pointer
  logic [BLK_PTR_W-1:0]  rd_blk_q;   // reads go a whole block at a time
  logic [FIFO_CNT_W-1:0] count_q;    // stored entries
  logic                  full;
  logic                  wr_en;
  logic                  rd_en;

  assign full  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
  assign wr_en = push_i & hi_sel_q & ~full;    // pair completed, dropped when full
  assign rd_en = pop_i & stat_o.block_avail;   // pop w/o a block ignored

  // ----------------------------------------
  // pointers, count and pairing
  // ----------------------------------------
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i || !sha_rstn_i) begin
      hi_sel_q <= 1'b0;
      wr_ptr_q <= '0;
      rd_blk_q <= '0;
      count_q  <= '0;
    end else begin
      if (restart_i)
        hi_sel_q <= 1'b0;  // back to the low half
      else if (push_i)
        hi_sel_q <= ~hi_sel_q;
      if (wr_en)
        wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
      if (rd_en)
        rd_blk_q <= rd_blk_q + 1'b1;
      count_q <= count_q + FIFO_CNT_W'(wr_en)
                 - (rd_en ? FIFO_CNT_W'(WORDS_PER_BLOCK) : '0);
    end
  end

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge clk_100mhz) begin
    if (push_i && !hi_sel_q)
      lo_word_q <= wdata_i;
    if (wr_en)
      mem_q[wr_ptr_q] <= {wdata_i, lo_word_q};  // second word on top
  end

  // oldest block, first entry in the low bits
  always_comb begin
    for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
      block_o[i*MSG_W +: MSG_W] = mem_q[{rd_blk_q, WORD_IDX_W'(i)}];
    end
  end

  assign stat_o.full        = full;
  assign stat_o.almost_full = (count_q == FIFO_CNT_W'(FIFO_DEPTH - 1));
  assign stat_o.empty       = (count_q == '0);
  assign stat_o.block_avail = (count_q >= FIFO_CNT_W'(WORDS_PER_BLOCK));

  // count matches the pointer distance modulo depth
  a_count_bound: assert property (@(posedge clk_100mhz) disable iff (!rstn_i)
    count_q <= FIFO_CNT_W'(FIFO_DEPTH) &&
    FIFO_PTR_W'(count_q) == wr_ptr_q - {rd_blk_q, WORD_IDX_W'(0)});

endmodule

/* ctrl_regs.sv */
`timescale 1ns/1ps

module ctrl_regs (
  input  logic                                   clk_100mhz,
  input  logic                                   rstn_i,
  input  logic                                   ctrl_we_i,
  input  logic                                   sha_ctrl_we_i,
  input  logic [sha256_frontend_pkg::DATA_W-1:0] wdata_i,
  output logic [sha256_frontend_pkg::DATA_W-1:0] ctrl_o,
  output logic [sha256_frontend_pkg::DATA_W-1:0] sha_ctrl_o,
  output sha256_frontend_pkg::sha_ctrl_t         flags_o,
  output logic                                   block_rstn_o,
  output logic                                   sha_rstn_o
);
  import sha256_frontend_pkg::*;

  logic [DATA_W-1:0] ctrl_q;
  logic [DATA_W-1:0] sha_ctrl_q;
  logic              block_rstn_q;  // block-local reset, active low

  // ----------------------------------------
  // register file
  // ----------------------------------------
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      ctrl_q     <= '0;
      sha_ctrl_q <= '0;
    end else begin
      if (ctrl_we_i)
        ctrl_q <= wdata_i;
      if (sha_ctrl_we_i)
        sha_ctrl_q <= wdata_i;
      else
        sha_ctrl_q <= sha_ctrl_q & ~ONESHOT_MASK;  // one-shots live one cycle
    end
  end

  // ----------------------------------------
  // block-local reset from enable bit
  // ----------------------------------------
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i)
      block_rstn_q <= 1'b0;  // held until chip reset released
    else
      block_rstn_q <= ctrl_q[ENABLE];  // one cycle behind the bit
  end

  assign ctrl_o     = ctrl_q;
  assign sha_ctrl_o = sha_ctrl_q;

  assign flags_o.reset    = sha_ctrl_q[RESET];
  assign flags_o.start    = sha_ctrl_q[START];
  assign flags_o.finalize = sha_ctrl_q[FINALIZE];

  assign block_rstn_o = block_rstn_q;
  assign sha_rstn_o   = block_rstn_q & ~sha_ctrl_q[RESET];  // sha part also resets on flag

  // bus spacing keeps writes two cycles apart, so a flag never sticks
  a_oneshot_pulse: assert property (@(posedge clk_100mhz) disable iff (!rstn_i)
    |(sha_ctrl_q & ONESHOT_MASK) |=> (sha_ctrl_q & ONESHOT_MASK) == '0);

endmodule

/* sys_bus_slave.sv */
`timescale 1ns/1ps

module sys_bus_slave (
  input  logic                                   clk_100mhz,
  input  logic                                   rstn_i,
  input  sha256_frontend_pkg::sys_req_t          sys_req_i,
  output sha256_frontend_pkg::sys_rsp_t          sys_rsp_o,
  output logic                                   ctrl_we_o,
  output logic                                   sha_ctrl_we_o,
  output logic [sha256_frontend_pkg::DATA_W-1:0] wdata_o,
  output logic                                   push_o,
  input  logic [sha256_frontend_pkg::DATA_W-1:0] ctrl_i,
  input  logic [sha256_frontend_pkg::DATA_W-1:0] sha_ctrl_i,
  input  logic                                   activated_i,
  input  logic                                   sha_en_i,
  input  sha256_frontend_pkg::fifo_stat_t        fifo_stat_i,
  input  sha256_frontend_pkg::eng_rsp_t          eng_rsp_i
);
  import sha256_frontend_pkg::*;

  reg_addr_e         addr;
  logic [DATA_W-1:0] status_w;      // global status
  logic [DATA_W-1:0] sha_status_w;  // sha256 status
  logic [DATA_W-1:0] rdata_d;
  logic              ctrl_we_d;
  logic              sha_ctrl_we_d;
  logic              push_d;

  assign addr = reg_addr_e'(sys_req_i.addr[ADDR_DECODE_W-1:0]);  // upper bits ignored

  assign status_w     = {27'b0, sha_en_i, 3'b0, activated_i};
  assign sha_status_w = {24'b0, fifo_stat_i.block_avail, fifo_stat_i.full,
                         fifo_stat_i.almost_full, fifo_stat_i.empty,
                         2'b0, eng_rsp_i.valid, eng_rsp_i.ready};

  // ----------------------------------------
  // address decode
  // ----------------------------------------
  always_comb begin
    rdata_d       = '0;  // unmapped reads give 0
    ctrl_we_d     = 1'b0;
    sha_ctrl_we_d = 1'b0;
    push_d        = 1'b0;
    case (addr)
      CTRL: begin
        rdata_d   = ctrl_i;
        ctrl_we_d = sys_req_i.wen;
      end
      STATUS:     rdata_d = status_w;
      VERSION:    rdata_d = BUILD_DATE;
      SHA_CTRL: begin
        rdata_d       = sha_ctrl_i;
        sha_ctrl_we_d = sys_req_i.wen;
      end
      SHA_STATUS: rdata_d = sha_status_w;
      SHA_PUSH:   push_d  = sys_req_i.wen;  // reads back 0
      SHA_HASH0:  rdata_d = eng_rsp_i.hash[0*DATA_W +: DATA_W];
      SHA_HASH1:  rdata_d = eng_rsp_i.hash[1*DATA_W +: DATA_W];
      SHA_HASH2:  rdata_d = eng_rsp_i.hash[2*DATA_W +: DATA_W];
      SHA_HASH3:  rdata_d = eng_rsp_i.hash[3*DATA_W +: DATA_W];
      SHA_HASH4:  rdata_d = eng_rsp_i.hash[4*DATA_W +: DATA_W];
      SHA_HASH5:  rdata_d = eng_rsp_i.hash[5*DATA_W +: DATA_W];
      SHA_HASH6:  rdata_d = eng_rsp_i.hash[6*DATA_W +: DATA_W];
      SHA_HASH7:  rdata_d = eng_rsp_i.hash[7*DATA_W +: DATA_W];
      default:    rdata_d = '0;
    endcase
  end

  // ----------------------------------------
  // ack, strobes and read data
  // ----------------------------------------
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      sys_rsp_o.ack <= 1'b0;
      ctrl_we_o     <= 1'b0;
      sha_ctrl_we_o <= 1'b0;
      push_o        <= 1'b0;
    end else begin
      sys_rsp_o.ack <= sys_req_i.wen | sys_req_i.ren;  // every address acks
      ctrl_we_o     <= ctrl_we_d;
      sha_ctrl_we_o <= sha_ctrl_we_d;
      push_o        <= push_d;
    end
  end

  // payload, only meaningful with ack or a strobe
  always_ff @(posedge clk_100mhz) begin
    sys_rsp_o.rdata <= sys_req_i.ren ? rdata_d : '0;
    wdata_o         <= sys_req_i.wdata;
  end

  // master waits for ack before the next request
  a_ack_single: assert property (@(posedge clk_100mhz) disable iff (!rstn_i)
    sys_rsp_o.ack |=> !sys_rsp_o.ack);

endmodule

/* sha256_frontend_pkg.sv */
package sha256_frontend_pkg;

  // ----------------------------------------
  // widths and depths
  // ----------------------------------------
  localparam int DATA_W          = 32;   // one bus word
  localparam int ADDR_DECODE_W   = 20;   // low address bits decoded
  localparam int MSG_W           = 64;   // one fifo entry, two bus words
  localparam int BLOCK_W         = 512;  // hash input block
  localparam int HASH_W          = 256;
  localparam int WORDS_PER_BLOCK = 8;    // fifo entries per block
  localparam int FIFO_DEPTH      = 128;  // 16 blocks

  localparam int WORD_IDX_W = $clog2(WORDS_PER_BLOCK);     // entry index within a block
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);          // entry pointer
  localparam int BLK_PTR_W  = FIFO_PTR_W - WORD_IDX_W;     // block pointer
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);      // 0 .. FIFO_DEPTH

  // version word, YYMMDDss layout
  localparam logic [DATA_W-1:0] BUILD_DATE = 32'h0000_0001;

  // sha ctrl bits 3..0 clear themselves
  localparam logic [DATA_W-1:0] ONESHOT_MASK = 32'h0000_000f;

  // ----------------------------------------
  // register map, byte addresses
  // ----------------------------------------
  typedef enum logic [ADDR_DECODE_W-1:0] {
    CTRL       = 20'h00000,
    STATUS     = 20'h00004,
    VERSION    = 20'h0000c,
    SHA_CTRL   = 20'h00100,
    SHA_STATUS = 20'h00104,
    SHA_PUSH   = 20'h0010c,  // write only
    SHA_HASH0  = 20'h00110,  // hash bits 31..0
    SHA_HASH1  = 20'h00114,
    SHA_HASH2  = 20'h00118,
    SHA_HASH3  = 20'h0011c,
    SHA_HASH4  = 20'h00120,
    SHA_HASH5  = 20'h00124,
    SHA_HASH6  = 20'h00128,
    SHA_HASH7  = 20'h0012c   // hash bits 255..224
  } reg_addr_e;

  typedef enum logic [4:0] {
    ENABLE = 5'd0            // global block enable
  } ctrl_bit_e;

  typedef enum logic [4:0] {
    RESET    = 5'd0,         // reset engine and fifo
    START    = 5'd1,         // kick the engine
    FINALIZE = 5'd2          // no more data follows
  } sha_ctrl_bit_e;

  // ----------------------------------------
  // bundles
  // ----------------------------------------
  typedef struct packed {
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              wen;
    logic              ren;
  } sys_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              ack;
  } sys_rsp_t;

  typedef struct packed {
    logic finalize;
    logic start;
    logic reset;
  } sha_ctrl_t;

  typedef struct packed {
    logic full;
    logic almost_full;       // one entry free
    logic empty;
    logic block_avail;       // at least one whole block stored
  } fifo_stat_t;

  typedef struct packed {
    logic [BLOCK_W-1:0] block;  // oldest block, first entry lowest
    logic               start;
  } eng_req_t;

  typedef struct packed {
    logic              ready;
    logic              valid;
    logic [HASH_W-1:0] hash;
  } eng_rsp_t;

endpackage
